/* src/zx_pkg.sv */
//==================================================
// ZX Spectrum memory and I/O shared definitions
// Bus types, machine mode, key matrix and the
// bit layout of the 128K paging port
//==================================================

package zx_pkg;

	//==================================================
	// Z80 bus types
	//==================================================
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Offset inside one 16 KiB bank
	typedef logic [13:0] bank_offset_t;

	// Number of a 16 KiB memory page
	typedef logic [7:0]  page_num_t;

	// Machine flavour picked up at reset
	typedef enum logic {
		MACHINE_48K  = 1'b0,
		MACHINE_128K = 1'b1
	} machine_e;

	// 8 half-rows of 5 keys where 1 means pressed
	typedef logic [7:0][4:0] key_matrix_t;

	//==================================================
	// Paging constants
	//==================================================
	// Fixed RAM pages behind CPU banks 1 and 2
	localparam page_num_t PAGE_SCREEN_NORMAL = 8'd5;
	localparam page_num_t PAGE_BANK_2        = 8'd2;

	// Port 7FFD bit layout
	localparam int P7FFD_PAGE_LSB = 0;
	localparam int P7FFD_PAGE_MSB = 2;
	localparam int P7FFD_SCR_BIT  = 3;
	localparam int P7FFD_ROM_BIT  = 4;
	localparam int P7FFD_LOCK_BIT = 5;

endpackage

/* src/zx_bus_if.sv */
//==================================================
// Decoded Z80 bus events
// Carries address, write data and the qualified
// I/O and memory strobes to the consumers
//==================================================
`timescale 1ns/1ps

interface zx_bus_if
	import zx_pkg::*;
();

	cpu_addr_t addr;
	cpu_data_t data;

	// Single-cycle pulse at the start of an I/O write
	logic io_wr_stb;

	// Levels that follow the Z80 strobes
	logic io_rd;
	logic mem_rd;
	logic mem_wr;

	modport decoder (
		output addr, data, io_wr_stb, io_rd, mem_rd, mem_wr
	);

	modport consumer (
		input addr, data, io_wr_stb, io_rd, mem_rd, mem_wr
	);

endinterface

/* src/bus_decoder.sv */
//==================================================
// Z80 bus decoder
// Turns the active-low CPU strobes into an edge
// detected I/O write pulse and level requests
//==================================================
`timescale 1ns/1ps

module bus_decoder
	import zx_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,

	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_dout,
	input  logic      mreq_n,
	input  logic      iorq_n,
	input  logic      rd_n,
	input  logic      wr_n,
	input  logic      m1_n,

	zx_bus_if.decoder bus
);

	logic io_wr;
	logic io_wr_prev;

	//==================================================
	// I/O cycle qualification
	//==================================================
	// M1 low with IORQ low is an interrupt acknowledge
	// and must not be seen as a port access
	assign io_wr = ~iorq_n & ~wr_n & m1_n;

	// Previous level of the write condition
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev <= 1'b0;
		end else begin
			io_wr_prev <= io_wr;
		end
	end

	// High only in the first cycle the condition is seen
	assign bus.io_wr_stb = io_wr & ~io_wr_prev;

	// Reads are consumed combinationally so a level is enough
	assign bus.io_rd = ~iorq_n & ~rd_n & m1_n;

	//==================================================
	// Memory requests
	//==================================================
	assign bus.mem_rd = ~mreq_n & ~rd_n;
	assign bus.mem_wr = ~mreq_n & ~wr_n;

	// Address and write data pass straight through
	assign bus.addr = cpu_addr;
	assign bus.data = cpu_dout;

endmodule

/* src/page_ctrl.sv */
//==================================================
// 128K paging register
// Port 7FFD with RAM page, screen, ROM and lock
// bits, plus the machine mode taken at reset
//==================================================
`timescale 1ns/1ps

module page_ctrl
	import zx_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       machine_128k,

	zx_bus_if.consumer bus,

	output machine_e   machine,
	output page_num_t  ram_page,
	output logic       rom_sel,
	output logic       page_scr
);

	logic [P7FFD_PAGE_MSB:P7FFD_PAGE_LSB] page_field;
	logic                                 scr_bit;
	logic                                 rom_bit;
	logic                                 lock_bit;
	logic                                 port_hit;
	logic                                 page_write;

	//==================================================
	// Port decode
	//==================================================
	// Partial decode as on the real machine with A15 and A1 low
	assign port_hit = ~bus.addr[15] & ~bus.addr[1];

	// Paging is frozen on a 48K machine or once locked
	assign page_write = bus.io_wr_stb & port_hit &
		(machine == MACHINE_128K) & ~lock_bit;

	//==================================================
	// Paging register
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine    <= machine_128k ? MACHINE_128K : MACHINE_48K;
			page_field <= '0;
			scr_bit    <= 1'b0;
			rom_bit    <= 1'b0;
			lock_bit   <= 1'b0;
		end else if (page_write) begin
			page_field <= bus.data[P7FFD_PAGE_MSB:P7FFD_PAGE_LSB];
			scr_bit    <= bus.data[P7FFD_SCR_BIT];
			rom_bit    <= bus.data[P7FFD_ROM_BIT];
			// Lock is sticky until the next reset
			lock_bit   <= bus.data[P7FFD_LOCK_BIT];
		end
	end

	// Only the low page bits exist on a standard 128K
	assign ram_page = page_num_t'(page_field);
	assign rom_sel  = rom_bit;
	assign page_scr = scr_bit;

endmodule

/* src/ula_port.sv */
//==================================================
// ULA port FE
// Border colour, EAR and MIC latch and the
// beeper audio sum with the tape input
//==================================================
`timescale 1ns/1ps

module ula_port
	import zx_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	zx_bus_if.consumer  bus,

	input  logic        tape_in,
	output logic [2:0]  border_color,
	output logic        ear,
	output logic [15:0] audio
);

	logic mic;
	logic ula_we;

	// Any even port reaches the ULA
	assign ula_we = bus.io_wr_stb & ~bus.addr[0];

	//==================================================
	// Output latch
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear          <= 1'b0;
			mic          <= 1'b0;
		end else if (ula_we) begin
			border_color <= bus.data[2:0];
			mic          <= bus.data[3];
			ear          <= bus.data[4];
		end
	end

	//==================================================
	// Beeper mix
	//==================================================
	// EAR weighs 8192, MIC 4096 and the tape input 2048
	assign audio = {2'b00, ear, mic, tape_in, 11'd0};

endmodule

/* src/mem_mapper.sv */
//==================================================
// Memory address mapper
// Maps the four 16 KiB CPU banks onto a linear
// memory address and write-protects the ROM
//==================================================
`timescale 1ns/1ps

module mem_mapper
	import zx_pkg::*;
#(
	parameter int RAM_ADDR_W    = 25,
	parameter int ROM_BASE_PAGE = 128
)
(
	zx_bus_if.consumer       bus,

	input  page_num_t        ram_page,
	input  logic             rom_sel,
	input  machine_e         machine,

	output logic [RAM_ADDR_W-1:0] ram_addr,
	output cpu_data_t        ram_din,
	output logic             ram_rd,
	output logic             ram_we
);

	// Page number takes whatever is left above the bank offset
	localparam int PAGE_W = RAM_ADDR_W - 14;

	logic [1:0]        bank;
	bank_offset_t      offset;
	logic              rom_num;
	logic [PAGE_W-1:0] page;

	assign bank   = bus.addr[15:14];
	assign offset = bus.addr[13:0];

	// The 48K machine always runs from the second ROM
	assign rom_num = (machine == MACHINE_128K) ? rom_sel : 1'b1;

	//==================================================
	// Bank to page
	//==================================================
	always_comb begin
		case (bank)
			2'd0: page = PAGE_W'(ROM_BASE_PAGE) + PAGE_W'(rom_num);
			2'd1: page = PAGE_W'(PAGE_SCREEN_NORMAL);
			2'd2: page = PAGE_W'(PAGE_BANK_2);
			default: begin
				if (machine == MACHINE_128K) begin
					page = PAGE_W'(ram_page);
				end else begin
					page = '0;
				end
			end
		endcase
	end

	assign ram_addr = {page, offset};
	assign ram_din  = bus.data;
	assign ram_rd   = bus.mem_rd;

	// Bank 0 holds ROM and ignores CPU writes
	assign ram_we = bus.mem_wr & (bank != 2'd0);

endmodule

/* src/cpu_read_mux.sv */
//==================================================
// CPU read data mux
// Memory data, keyboard port FE, or FF for all
// other ports
//==================================================
`timescale 1ns/1ps

module cpu_read_mux
	import zx_pkg::*;
(
	zx_bus_if.consumer bus,

	input  cpu_data_t   ram_dout,
	input  key_matrix_t key_matrix,
	input  logic        tape_in,
	output cpu_data_t   cpu_din
);

	logic [4:0] keys_down;

	// A half-row is scanned when its high address bit is low
	always_comb begin
		keys_down = 5'd0;
		for (int r = 0; r < 8; r++) begin
			if (!bus.addr[8 + r]) begin
				keys_down = keys_down | key_matrix[r];
			end
		end
	end

	always_comb begin
		if (bus.mem_rd) begin
			cpu_din = ram_dout;
		end else if (bus.io_rd && !bus.addr[0]) begin
			// Keys read back active low
			cpu_din = {1'b1, ~tape_in, 1'b1, ~keys_down};
		end else begin
			cpu_din = 8'hFF;
		end
	end

endmodule

/* src/zx_mem_io.sv */
//==================================================
// ZX Spectrum 48K/128K memory and I/O glue
// Bus decode, 7FFD paging, ULA port, memory map
// and CPU read data between Z80 and memory
//==================================================
`timescale 1ns/1ps

module zx_mem_io
	import zx_pkg::*;
#(
	parameter int RAM_ADDR_W    = 25,
	parameter int ROM_BASE_PAGE = 128
)
(
	input  logic                  clk_sys,
	input  logic                  reset,

	// Z80 bus
	input  cpu_addr_t             cpu_addr,
	input  cpu_data_t             cpu_dout,
	output cpu_data_t             cpu_din,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  m1_n,

	input  logic                  machine_128k,

	// System memory
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output cpu_data_t             ram_din,
	input  cpu_data_t             ram_dout,
	output logic                  ram_rd,
	output logic                  ram_we,

	// ULA side
	output logic                  page_scr,
	output logic [2:0]            border_color,
	output logic                  ear,
	output logic [15:0]           audio,
	input  logic                  tape_in,
	input  key_matrix_t           key_matrix
);

	machine_e  machine;
	page_num_t ram_page;
	logic      rom_sel;

	zx_bus_if bus_if ();

	//==================================================
	// Bus decode
	//==================================================
	bus_decoder bus_decoder_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.mreq_n   (mreq_n),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.bus      (bus_if.decoder)
	);

	//==================================================
	// Port registers
	//==================================================
	page_ctrl page_ctrl_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine_128k (machine_128k),
		.bus          (bus_if.consumer),
		.machine      (machine),
		.ram_page     (ram_page),
		.rom_sel      (rom_sel),
		.page_scr     (page_scr)
	);

	ula_port ula_port_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus_if.consumer),
		.tape_in      (tape_in),
		.border_color (border_color),
		.ear          (ear),
		.audio        (audio)
	);

	//==================================================
	// Memory and read data
	//==================================================
	mem_mapper #(
		.RAM_ADDR_W    (RAM_ADDR_W),
		.ROM_BASE_PAGE (ROM_BASE_PAGE)
	) mem_mapper_inst (
		.bus      (bus_if.consumer),
		.ram_page (ram_page),
		.rom_sel  (rom_sel),
		.machine  (machine),
		.ram_addr (ram_addr),
		.ram_din  (ram_din),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we)
	);

	cpu_read_mux cpu_read_mux_inst (
		.bus        (bus_if.consumer),
		.ram_dout   (ram_dout),
		.key_matrix (key_matrix),
		.tape_in    (tape_in),
		.cpu_din    (cpu_din)
	);

endmodule

/* tests/tb_zx_checks.svh */
//==================================================
// Reference model and checks for the memory and
// I/O glue testbench
//==================================================
`ifndef TB_ZX_CHECKS_SVH
`define TB_ZX_CHECKS_SVH

int mismatch_errors = 0;
int other_errors = 0;

// Linear address a CPU address should map to with the current paging
function automatic logic [RAM_ADDR_W-1:0] exp_ram_addr(input cpu_addr_t a);
	int page;
	case (a[15:14])
		2'd0: page = ROM_BASE_PAGE + (m_128k ? int'(m_rom) : 1);
		2'd1: page = 5;
		2'd2: page = 2;
		default: page = m_128k ? int'(m_page) : 0;
	endcase
	return RAM_ADDR_W'(page * 16384 + int'(a[13:0]));
endfunction

// Beeper weighting of EAR, MIC and tape input
function automatic logic [15:0] exp_audio();
	return 16'(int'(m_ear) * 8192 + int'(m_mic) * 4096 + int'(tape_in) * 2048);
endfunction

// Byte seen by the CPU on an I/O read
function automatic cpu_data_t exp_port_byte(input cpu_addr_t a, input key_matrix_t km,
	input logic tape);
	cpu_data_t b;
	b = 8'hFF;
	if (!a[0]) begin
		b[6] = ~tape;
		for (int k = 0; k < 5; k++) begin
			for (int r = 0; r < 8; r++) begin
				if (!a[8 + r] && km[r][k]) begin
					b[k] = 1'b0;
				end
			end
		end
	end
	return b;
endfunction

function automatic logic ports_match();
	return border_color == m_border && ear == m_ear && page_scr == m_scr &&
		audio == exp_audio();
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		mismatch_errors++;
		$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
	end
endtask

// ROM bank never reaches the memory write enable
rom_write_blocked: assert property (@(posedge clk_sys) disable iff (reset)
	ram_we |-> (cpu_addr[15:14] != 2'b00)) else begin
	other_errors++;
	$display("Memory write enable raised for ROM address %h at %0t ns", cpu_addr, $time);
end

// No memory strobe while MREQ is idle
idle_quiet: assert property (@(posedge clk_sys) disable iff (reset)
	mreq_n |-> (!ram_rd && !ram_we)) else begin
	other_errors++;
	$display("Memory strobe active without MREQ at %0t ns", $time);
end

`endif

/* tests/tb_zx_mem_io.sv */
//==================================================
// Testbench for the ZX Spectrum memory and I/O glue
// Z80 bus cycles checked against a reference model
//==================================================
`timescale 1ns/1ps

module tb_zx_mem_io
	import zx_pkg::*;
();
	localparam int RAM_ADDR_W = 25;
	localparam int ROM_BASE_PAGE = 128;

	logic clk_sys, reset, machine_128k, tape_in;
	logic mreq_n, iorq_n, rd_n, wr_n, m1_n;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_dout, cpu_din, ram_din, ram_dout;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic ram_rd, ram_we, page_scr, ear;
	logic [2:0] border_color;
	logic [15:0] audio;
	key_matrix_t key_matrix;

	// Model of the port registers
	logic m_128k, m_scr, m_rom, m_lock, m_ear, m_mic;
	logic [2:0] m_page, m_border;
	integer seed = 32'h6d60_c125;
	logic [31:0] rnd;

	`include "tb_zx_checks.svh"

	zx_mem_io #(
		.RAM_ADDR_W    (RAM_ADDR_W),
		.ROM_BASE_PAGE (ROM_BASE_PAGE)
	) zx_mem_io_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic apply_reset(input logic mode);
		@(negedge clk_sys);
		reset = 1'b1;
		machine_128k = mode;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
		// The mode is held from reset alone
		machine_128k = ~mode;
		{m_page, m_scr, m_rom, m_lock, m_border, m_ear, m_mic} = '0;
		m_128k = mode;
	endtask

	task automatic mem_cycle(input cpu_addr_t a, input cpu_data_t d, input logic write);
		@(negedge clk_sys);
		rnd = $random(seed);
		cpu_addr = a;
		cpu_dout = d;
		ram_dout = rnd[7:0];
		mreq_n = 1'b0;
		rd_n = write;
		wr_n = !write;
		repeat (3) @(negedge clk_sys);
		check_eq("ram_addr", 32'(ram_addr), 32'(exp_ram_addr(a)));
		check_eq("ram_rd", 32'(ram_rd), 32'(!write));
		check_eq("ram_we", 32'(ram_we), 32'(write && a[15:14] != 2'd0));
		if (write) begin
			check_eq("ram_din", 32'(ram_din), 32'(d));
		end else begin
			check_eq("cpu_din", 32'(cpu_din), 32'(ram_dout));
		end
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic io_write(input cpu_addr_t a, input cpu_data_t d);
		int waited;
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_dout = d;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		if (!a[0]) begin
			{m_ear, m_mic, m_border} = d[4:0];
		end
		if (!a[15] && !a[1] && m_128k && !m_lock) begin
			{m_lock, m_rom, m_scr, m_page} = d[5:0];
		end
		// Port registers follow within two clocks
		waited = 0;
		while (!ports_match() && waited < 2) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!ports_match()) begin
			other_errors++;
			$display("Timeout: write of %h to port %h not visible after 2 clocks", d, a);
		end
		while (waited < 3) begin
			@(negedge clk_sys);
			waited++;
		end
		iorq_n = 1'b1;
		wr_n = 1'b1;
		check_eq("border_color", 32'(border_color), 32'(m_border));
		check_eq("ear", 32'(ear), 32'(m_ear));
		check_eq("page_scr", 32'(page_scr), 32'(m_scr));
		check_eq("audio", 32'(audio), 32'(exp_audio()));
	endtask

	// IORQ with M1 low is an interrupt acknowledge and must not reach the ports
	task automatic int_ack_cycle(input cpu_addr_t a, input cpu_data_t d);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_dout = d;
		m1_n = 1'b0;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		wr_n = 1'b0;
		repeat (3) @(negedge clk_sys);
		check_eq("cpu_din", 32'(cpu_din), 32'hFF);
		m1_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		check_eq("border_color", 32'(border_color), 32'(m_border));
		check_eq("ear", 32'(ear), 32'(m_ear));
		check_eq("page_scr", 32'(page_scr), 32'(m_scr));
	endtask

	task automatic io_read(input cpu_addr_t a);
		@(negedge clk_sys);
		rnd = $random(seed);
		cpu_addr = a;
		key_matrix = {rnd[7:0], $random(seed)};
		tape_in = rnd[8];
		iorq_n = 1'b0;
		rd_n = 1'b0;
		repeat (3) @(negedge clk_sys);
		check_eq("cpu_din", 32'(cpu_din), 32'(exp_port_byte(a, key_matrix, tape_in)));
		iorq_n = 1'b1;
		rd_n = 1'b1;
	endtask

	initial begin
		{reset, machine_128k, tape_in} = 3'b110;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
		cpu_addr = '0;
		cpu_dout = '0;
		ram_dout = '0;
		key_matrix = '0;
		{m_128k, m_page, m_scr, m_rom, m_lock, m_border, m_ear, m_mic} = '0;

		// Reset state in 128K mode
		apply_reset(1'b1);
		check_eq("border_color", 32'(border_color), 32'd0);
		check_eq("ear", 32'(ear), 32'd0);
		check_eq("audio", 32'(audio), 32'd0);
		check_eq("ram_rd", 32'(ram_rd), 32'd0);
		check_eq("ram_we", 32'(ram_we), 32'd0);
		mem_cycle(16'h0000, 8'h00, 1'b0);
		mem_cycle(16'h4000, 8'h00, 1'b0);
		mem_cycle(16'h8000, 8'h00, 1'b0);
		mem_cycle(16'hC000, 8'h00, 1'b0);

		// Paging and a write to a port with A1 set
		io_write(16'h7FFD, 8'h13);
		mem_cycle(16'hC010, 8'h00, 1'b0);
		mem_cycle(16'h0010, 8'h00, 1'b0);
		io_write(16'h7FFD, 8'h0E);
		mem_cycle(16'hC5A5, 8'h00, 1'b0);
		io_write(16'h7FFF, 8'h11);
		int_ack_cycle(16'h00FC, 8'h17);
		mem_cycle(16'hC000, 8'h00, 1'b0);
		mem_cycle(16'h0000, 8'h00, 1'b0);
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			io_write(16'h7FFD, rnd[31:24] & 8'h1F);
			mem_cycle({2'b11, rnd[13:0]}, 8'h00, 1'b0);
			mem_cycle({2'b00, rnd[13:0]}, 8'h00, 1'b0);
		end

		// Lock and then 48K mode
		io_write(16'h7FFD, 8'h21);
		io_write(16'h7FFD, 8'h17);
		mem_cycle(16'hC123, 8'h00, 1'b0);
		apply_reset(1'b0);
		io_write(16'h7FFD, 8'h0F);
		mem_cycle(16'hC000, 8'h00, 1'b0);
		mem_cycle(16'h1234, 8'h00, 1'b0);

		// ROM write protection
		apply_reset(1'b1);
		io_write(16'h7FFD, 8'h04);
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			mem_cycle({2'(i), rnd[13:0]}, rnd[23:16], 1'b1);
		end

		// ULA port and tape weight
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			io_write({rnd[15:1], 1'b0}, rnd[23:16]);
			@(negedge clk_sys);
			tape_in = ~tape_in;
			@(negedge clk_sys);
			check_eq("audio", 32'(audio), 32'(exp_audio()));
		end

		// Read mux
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			mem_cycle(rnd[15:0], 8'h00, 1'b0);
			io_read({rnd[31:24], 8'hFE});
			io_read({rnd[23:16], rnd[7:1], 1'b1});
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* zx_mem_io.f */
+incdir+tests
src/zx_pkg.sv
src/zx_bus_if.sv
src/bus_decoder.sv
src/page_ctrl.sv
src/ula_port.sv
src/mem_mapper.sv
src/cpu_read_mux.sv
src/zx_mem_io.sv
tests/tb_zx_mem_io.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_zx_mem_io
FILELIST  = zx_mem_io.f
OBJDIR    = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)
